// File: bench/exec_cluster_checker.sv
`include "exec_macros.svh"

module exec_cluster_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic req_credit_i,
  input logic rsp_valid_i,
  input logic rsp_credit_i
);

  int dn_credit_q;  // credits the collector may still spend.
  int up_held_q;    // requests inside the cluster whose credit is not back yet.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dn_credit_q <= `EXEC_OUT_CREDITS;
      up_held_q   <= 0;
    end else begin
      dn_credit_q <= dn_credit_q - int'(rsp_valid_i) + int'(rsp_credit_i);
      up_held_q   <= up_held_q + int'(req_valid_i) - int'(req_credit_i);
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !req_credit_i && !rsp_valid_i)
    else $error("credit or response output active right after reset");

  a_dn_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> dn_credit_q > 0)
    else $error("response sent without a downstream credit");

  a_up_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_credit_i |-> up_held_q > 0)
    else $error("credit returned for a request never received");

  // input buffer overflow.
  a_up_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> up_held_q < `EXEC_IN_CREDITS)
    else $error("request sent while the input buffer is full");

endmodule

bind exec_cluster exec_cluster_checker u_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_valid_i  (req_valid_i),
  .req_credit_i (req_credit_o),
  .rsp_valid_i  (rsp_valid_o),
  .rsp_credit_i (rsp_credit_i)
);

// File: bench/exec_cluster_tb.sv
`include "exec_macros.svh"

module exec_cluster_tb;

  import exec_isa_pkg::*;
  import exec_flow_pkg::*;

  localparam int n_arith  = 80;
  localparam int n_muldiv = 60 + 8;  // random, then the divide corners.
  localparam int n_mem    = 8 * 4 * 2;
  localparam int n_ctrl   = 24;
  localparam int n_burst  = 200;
  localparam int n_total  = n_arith + n_muldiv + n_mem + n_ctrl + n_burst;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  op_req_t   req;
  logic      req_credit;
  logic      rsp_valid;
  exec_rsp_t rsp;
  logic      rsp_credit = 1'b0;

  integer    seed = 32'h9b2c7030;
  exec_rsp_t exp_q [$];  // expected responses in issue order.
  int        up_credits;
  int        owed;         // downstream credits not yet returned.
  int        ret_rate;     // chance out of 16 of a credit return per cycle.
  logic      give_credit = 1'b0;
  int        sent = 0;
  int        received = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;
  int        mark_sent;
  int        mark_err;

  exec_cluster u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .rsp_credit_i (rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // reference model.
  ////////////////////

  function automatic byte_mask_t store_mask(input alu_op_e op, input byte_off_t off);
    case (op)
      OP_SB:   return {off == 3, off == 2, off == 1, off == 0};
      OP_SH:   return {off == 2, off == 2 || off == 1, off == 1 || off == 0, off == 0};
      OP_SW:   return {4{off == 0}};
      default: return '0;
    endcase
  endfunction

  function automatic exec_rsp_t model_rsp(input alu_op_e op, input word_t a, input word_t b);
    exec_rsp_t       r;
    int              sa;
    int              sb;
    longint          ps;
    longint unsigned pu;
    word_t           ea;
    r    = '0;
    r.op = op;
    sa   = a;
    sb   = b;
    ps   = longint'(sa) * longint'(sb);
    pu   = {32'b0, a} * {32'b0, b};
    ea   = a + b;
    case (op)
      OP_ADD:            r.alu_result = a + b;
      OP_SUB:            r.alu_result = a - b;
      OP_XOR:            r.alu_result = a ^ b;
      OP_OR:             r.alu_result = a | b;
      OP_AND:            r.alu_result = a & b;
      OP_SLL:            r.alu_result = a << b[4:0];
      OP_SRL:            r.alu_result = a >> b[4:0];
      OP_SRA:            r.alu_result = word_t'(sa >>> b[4:0]);
      OP_SLT, OP_SLTI:   r.alu_result = (sa < sb) ? 32'd1 : 32'd0;
      OP_SLTU, OP_SLTIU: r.alu_result = (a < b) ? 32'd1 : 32'd0;
      OP_JUMP:           r.alu_result = b + 32'd4;
      OP_CSRRW, OP_CSRRS: r.alu_result = a;
      OP_MUL:            r.alu_result = ps[31:0];
      OP_MULH:           r.alu_result = ps[63:32];
      OP_MULHU:          r.alu_result = pu[63:32];
      OP_DIV, OP_REM: begin
        if (b == 0) begin
          r.alu_result = (op == OP_DIV) ? 32'hffff_ffff : a;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          r.alu_result = (op == OP_DIV) ? a : 32'h0;  // signed overflow.
        end else begin
          r.alu_result = (op == OP_DIV) ? word_t'(sa / sb) : word_t'(sa % sb);
        end
      end
      OP_DIVU, OP_REMU: begin
        if (b == 0) begin
          r.alu_result = (op == OP_DIVU) ? 32'hffff_ffff : a;
        end else begin
          r.alu_result = (op == OP_DIVU) ? a / b : a % b;
        end
      end
      default:           r.alu_result = '0;
    endcase
    if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
      r.rmem_addr   = ea;
      r.read_offset = ea[1:0];
    end
    if (op inside {OP_SB, OP_SH, OP_SW}) begin
      r.wmem_addr = ea;
      r.wmem_mask = store_mask(op, ea[1:0]);
    end
    return r;
  endfunction

  ////////////////////
  // compare tasks.
  ////////////////////

  task automatic report_mismatch(input string name, input word_t got, input word_t want);
    errors++;
    $display("Error: rsp_o.%s got %h expected %h", name, got, want);
  endtask

  task automatic check_rsp(input exec_rsp_t got, input exec_rsp_t want);
    checks++;
    if (got.op !== want.op) report_mismatch("op", word_t'(got.op), word_t'(want.op));
    if (got.alu_result !== want.alu_result) begin
      report_mismatch("alu_result", got.alu_result, want.alu_result);
    end
    if (got.rmem_addr !== want.rmem_addr) begin
      report_mismatch("rmem_addr", got.rmem_addr, want.rmem_addr);
    end
    if (got.wmem_addr !== want.wmem_addr) begin
      report_mismatch("wmem_addr", got.wmem_addr, want.wmem_addr);
    end
    if (got.wmem_mask !== want.wmem_mask) begin
      report_mismatch("wmem_mask", word_t'(got.wmem_mask), word_t'(want.wmem_mask));
    end
    if (got.read_offset !== want.read_offset) begin
      report_mismatch("read_offset", word_t'(got.read_offset), word_t'(want.read_offset));
    end
  endtask

  task automatic check_count(input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("Error: response count got %h expected %h", got, want);
    end
  endtask

  ////////////////////
  // upstream and downstream.
  ////////////////////

  // called and left at 1 time unit after a rising edge.
  task automatic send_req(input alu_op_e op, input word_t a, input word_t b);
    while (up_credits == 0) begin
      @(posedge clk);
      #1;
    end
    req_valid    = 1'b1;
    req.op       = op;
    req.operand1 = a;
    req.operand2 = b;
    up_credits--;
    sent++;
    exp_q.push_back(model_rsp(op, a, b));
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  function automatic word_t rand_word();
    case ($random(seed) & 7)  // half of the operands sit on a boundary.
      0:       return 32'h8000_0000;
      1:       return 32'h7fff_ffff;
      2:       return 32'hffff_ffff;
      3:       return 32'h0;
      default: return $random(seed);
    endcase
  endfunction

  always @(negedge clk) begin
    if (rst_n && req_credit) up_credits++;
    if (rst_n && rsp_valid) begin
      received++;
      owed++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived while no request was outstanding");
      end else begin
        check_rsp(rsp, exp_q.pop_front());
      end
    end
    give_credit = (owed > 0) && (($random(seed) & 15) < ret_rate);
  end

  always @(posedge clk) begin
    #1;
    rsp_credit = give_credit;
    if (give_credit) owed--;
  end

  task automatic start_test();
    mark_sent = sent;
    mark_err  = errors;
  endtask

  task automatic finish_test(input string name);
    while (received < sent) begin
      @(posedge clk);
      #1;
    end
    repeat (10) @(posedge clk);  // nothing extra may follow.
    #1;
    check_count(received, sent);
    tests++;
    $display("test %0d %s: %0d requests, %0d errors", tests, name, sent - mark_sent,
             errors - mark_err);
  endtask

  initial begin
    repeat (n_total * 50) @(posedge clk);
    $display("timeout: responses stopped arriving before all requests were answered");
    $display("tests failed");
    $finish;
  end

  initial begin
    alu_op_e op;
    word_t   a;
    word_t   b;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    up_credits = `EXEC_IN_CREDITS;
    owed       = 0;
    ret_rate   = 12;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test();
    for (int i = 0; i < n_arith; i++) begin
      op = alu_op_e'(($random(seed) & 32'h7fff_ffff) % 12);  // OP_ADD to OP_SLTIU.
      a  = rand_word();
      b  = rand_word();
      send_req(op, a, b);
    end
    finish_test("alu, shift and compare");

    start_test();
    for (int i = 0; i < n_muldiv - 8; i++) begin
      op = alu_op_e'(int'(OP_MUL) + ($random(seed) & 32'h7fff_ffff) % 7);
      a  = rand_word();
      b  = rand_word();
      send_req(op, a, b);
    end
    for (int k = 0; k < 4; k++) begin
      op = alu_op_e'(int'(OP_DIV) + k);
      send_req(op, $random(seed), 32'h0);
      send_req(op, 32'h8000_0000, 32'hffff_ffff);
    end
    finish_test("multiply and divide");

    start_test();
    for (int k = int'(OP_LB); k <= int'(OP_SW); k++) begin
      for (int off = 0; off < 4; off++) begin
        repeat (2) begin
          a      = $random(seed);
          b      = $random(seed);
          b[1:0] = 2'(off) - a[1:0];
          send_req(alu_op_e'(k), a, b);
        end
      end
    end
    finish_test("loads and stores");

    start_test();
    for (int i = 0; i < n_ctrl; i++) begin
      send_req(alu_op_e'(int'(OP_JUMP) + i % 3), $random(seed), $random(seed));
    end
    finish_test("jump and csr");

    start_test();
    ret_rate = 1;
    for (int i = 0; i < n_burst; i++) begin
      op = alu_op_e'(($random(seed) & 32'h7fff_ffff) % 31);
      a  = rand_word();
      b  = rand_word();
      send_req(op, a, b);
    end
    finish_test("back-pressure burst");

    $display("%0d tests, %0d requests, %0d checks, %0d errors", tests, sent, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the exec cluster testbench with verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=exec_cluster_tb

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_cluster_tb -f verilog.f -o "$bin"; then
  echo "verilator build error"
  exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$log"; then
  exit 1
fi
exit 0

// File: verilog.f
+incdir+verilog
verilog/exec_isa_pkg.sv
verilog/exec_flow_pkg.sv
verilog/credit_fifo.sv
verilog/exec_dispatch.sv
verilog/exec_lane.sv
verilog/exec_collect.sv
verilog/exec_cluster.sv
bench/exec_cluster_checker.sv
bench/exec_cluster_tb.sv

// File: verilog/credit_fifo.sv
module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     empty_o,
  output payload_t head_o
);

  localparam int ptr_w = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w = $clog2(depth_p + 1);

  payload_t         mem_q [depth_p];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  // wrap at depth_p, which need not be a power of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or push and pop together.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign empty_o = (count_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

endmodule

// File: verilog/exec_cluster.sv
`include "exec_macros.svh"

module exec_cluster (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  input  exec_flow_pkg::op_req_t   req_i,
  output logic                     req_credit_o,
  output logic                     rsp_valid_o,
  output exec_flow_pkg::exec_rsp_t rsp_o,
  input  logic                     rsp_credit_i
);

  import exec_flow_pkg::*;

  logic [`EXEC_LANES-1:0] issue_valid;
  logic [`EXEC_LANES-1:0] lane_credit;
  logic [`EXEC_LANES-1:0] rsp_avail;
  logic [`EXEC_LANES-1:0] pop;
  op_req_t                issue_req;  // shared by all lanes.
  exec_rsp_t              rsp_data [`EXEC_LANES];

  exec_dispatch u_dispatch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .lane_credit_i (lane_credit),
    .issue_valid_o (issue_valid),
    .issue_req_o   (issue_req)
  );

  for (genvar k = 0; k < `EXEC_LANES; k++) begin : g_lane
    exec_lane u_lane (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .issue_valid_i (issue_valid[k]),
      .issue_req_i   (issue_req),
      .pop_i         (pop[k]),
      .rsp_avail_o   (rsp_avail[k]),
      .rsp_o         (rsp_data[k]),
      .lane_credit_o (lane_credit[k])
    );
  end

  exec_collect u_collect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rsp_avail_i  (rsp_avail),
    .rsp_i        (rsp_data),
    .pop_o        (pop),
    .rsp_credit_i (rsp_credit_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

// File: verilog/exec_collect.sv
`include "exec_macros.svh"

module exec_collect (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`EXEC_LANES-1:0]   rsp_avail_i,
  input  exec_flow_pkg::exec_rsp_t rsp_i [`EXEC_LANES],
  output logic [`EXEC_LANES-1:0]   pop_o,
  input  logic                     rsp_credit_i,
  output logic                     rsp_valid_o,
  output exec_flow_pkg::exec_rsp_t rsp_o
);

  import exec_flow_pkg::*;

  localparam int cnt_w = $clog2(`EXEC_OUT_CREDITS + 1);

  lane_idx_t        rr_ptr_q;     // follows the dispatcher's order.
  logic [cnt_w-1:0] credit_q;
  logic             do_pop;
  logic             rsp_valid_q;
  exec_rsp_t        rsp_q;

  assign do_pop = rsp_avail_i[rr_ptr_q] && (credit_q != '0);

  always_comb begin
    pop_o           = '0;
    pop_o[rr_ptr_q] = do_pop;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q    <= '0;
      credit_q    <= cnt_w'(`EXEC_OUT_CREDITS);
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= do_pop;
      if (do_pop) begin
        rr_ptr_q <= (rr_ptr_q == lane_idx_t'(`EXEC_LANES - 1)) ? '0 : rr_ptr_q + 1'b1;
      end
      case ({do_pop, rsp_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_pop) rsp_q <= rsp_i[rr_ptr_q];
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: verilog/exec_dispatch.sv
`include "exec_macros.svh"

module exec_dispatch (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  exec_flow_pkg::op_req_t req_i,
  output logic                   req_credit_o,
  input  logic [`EXEC_LANES-1:0] lane_credit_i,
  output logic [`EXEC_LANES-1:0] issue_valid_o,
  output exec_flow_pkg::op_req_t issue_req_o
);

  import exec_flow_pkg::*;

  localparam int cnt_w = $clog2(`EXEC_LANE_DEPTH + 1);

  logic [cnt_w-1:0] lane_cnt_q [`EXEC_LANES];  // free slots per lane.
  lane_idx_t        rr_ptr_q;
  logic             buf_empty;
  logic             do_issue;
  logic             req_credit_q;

  credit_fifo #(
    .payload_t (op_req_t),
    .depth_p   (`EXEC_IN_CREDITS)
  ) u_req_buf (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (req_valid_i),
    .push_data_i (req_i),
    .pop_i       (do_issue),
    .empty_o     (buf_empty),
    .head_o      (issue_req_o)
  );

  // strict round robin, so a lane without credit stalls the whole stream.
  assign do_issue = !buf_empty && (lane_cnt_q[rr_ptr_q] != '0);

  always_comb begin
    issue_valid_o           = '0;
    issue_valid_o[rr_ptr_q] = do_issue;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q     <= '0;
      req_credit_q <= 1'b0;
      for (int k = 0; k < `EXEC_LANES; k++) begin
        lane_cnt_q[k] <= cnt_w'(`EXEC_LANE_DEPTH);
      end
    end else begin
      req_credit_q <= do_issue;  // the buffer slot is free again.
      if (do_issue) begin
        rr_ptr_q <= (rr_ptr_q == lane_idx_t'(`EXEC_LANES - 1)) ? '0 : rr_ptr_q + 1'b1;
      end
      for (int k = 0; k < `EXEC_LANES; k++) begin
        case ({issue_valid_o[k], lane_credit_i[k]})
          2'b10:   lane_cnt_q[k] <= lane_cnt_q[k] - 1'b1;
          2'b01:   lane_cnt_q[k] <= lane_cnt_q[k] + 1'b1;
          default: lane_cnt_q[k] <= lane_cnt_q[k];
        endcase
      end
    end
  end

  assign req_credit_o = req_credit_q;

endmodule

// File: verilog/exec_flow_pkg.sv
`include "exec_macros.svh"

package exec_flow_pkg;

  import exec_isa_pkg::*;

  // decoded operation handed to the cluster.
  typedef struct packed {
    alu_op_e op;
    word_t   operand1;
    word_t   operand2;
  } op_req_t;

  // result of one operation, returned in issue order.
  typedef struct packed {
    alu_op_e    op;           // forwarded for the load expansion unit.
    word_t      alu_result;
    word_t      rmem_addr;
    word_t      wmem_addr;
    byte_mask_t wmem_mask;
    byte_off_t  read_offset;
  } exec_rsp_t;

  // selects one execute lane.
  typedef logic [$clog2(`EXEC_LANES)-1:0] lane_idx_t;

endpackage

// File: verilog/exec_isa_pkg.sv
`include "exec_macros.svh"

package exec_isa_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;

  typedef logic [3:0] byte_mask_t;  // one bit per byte of a word.
  typedef logic [1:0] byte_off_t;   // byte within a word.

  // decoded operation codes.
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SLT,
    OP_SRL,
    OP_SRA,
    OP_SLTU,
    OP_SLTI,
    OP_SLTIU,
    OP_JUMP,
    OP_CSRRW,
    OP_CSRRS,
    OP_MUL,
    OP_MULH,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,  // loads.
    OP_SB, OP_SH, OP_SW,                 // stores.
    OP_NOP
  } alu_op_e;

endpackage

// File: verilog/exec_lane.sv
`include "exec_macros.svh"

module exec_lane (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     issue_valid_i,
  input  exec_flow_pkg::op_req_t   issue_req_i,
  input  logic                     pop_i,
  output logic                     rsp_avail_o,
  output exec_flow_pkg::exec_rsp_t rsp_o,
  output logic                     lane_credit_o
);

  import exec_isa_pkg::*;
  import exec_flow_pkg::*;

  localparam word_t inst_len = word_t'(4);
  localparam word_t min_int  = {1'b1, {(`EXEC_XLEN - 1){1'b0}}};

  op_req_t   req_q;
  logic      req_vld_q;
  logic      lane_credit_q;
  logic      rsp_empty;
  exec_rsp_t rsp_d;

  word_t      op1;
  word_t      op2;
  word_t      ea;
  word_t      alu_result;
  word_t      den_s;
  word_t      den_u;
  word_t      quo_s;
  word_t      rem_s;
  logic       is_load;
  logic       is_store;
  logic       div_zero;
  logic       div_ovf;
  byte_mask_t wr_mask;

  logic signed [2*`EXEC_XLEN-1:0] prod_s;
  logic        [2*`EXEC_XLEN-1:0] prod_u;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_vld_q     <= 1'b0;
      lane_credit_q <= 1'b0;
    end else begin
      req_vld_q     <= issue_valid_i;
      lane_credit_q <= pop_i;  // one credit back per drained response.
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) req_q <= issue_req_i;
  end

  ////////////////////
  // alu.
  ////////////////////

  assign op1      = req_q.operand1;
  assign op2      = req_q.operand2;
  assign prod_s   = $signed(op1) * $signed(op2);
  assign prod_u   = op1 * op2;
  assign div_zero = (op2 == '0);
  assign div_ovf  = (op1 == min_int) && (op2 == '1);
  // a divisor of one yields the required results for the overflow case.
  assign den_s    = (div_zero || div_ovf) ? word_t'(1) : op2;
  assign den_u    = div_zero ? word_t'(1) : op2;
  assign quo_s    = $signed(op1) / $signed(den_s);
  assign rem_s    = $signed(op1) % $signed(den_s);

  always_comb begin
    case (req_q.op)
      OP_ADD:   alu_result = op1 + op2;
      OP_SUB:   alu_result = op1 - op2;
      OP_XOR:   alu_result = op1 ^ op2;
      OP_OR:    alu_result = op1 | op2;
      OP_AND:   alu_result = op1 & op2;
      OP_SLL:   alu_result = op1 << op2[4:0];
      OP_SRL:   alu_result = op1 >> op2[4:0];
      OP_SRA:   alu_result = $signed(op1) >>> op2[4:0];
      OP_SLT,
      OP_SLTI:  alu_result = word_t'($signed(op1) < $signed(op2));
      OP_SLTU,
      OP_SLTIU: alu_result = word_t'(op1 < op2);
      OP_JUMP:  alu_result = inst_len + op2;  // link address.
      OP_CSRRW,
      OP_CSRRS: alu_result = op1;
      OP_MUL:   alu_result = prod_s[`EXEC_XLEN-1:0];
      OP_MULH:  alu_result = prod_s[2*`EXEC_XLEN-1:`EXEC_XLEN];
      OP_MULHU: alu_result = prod_u[2*`EXEC_XLEN-1:`EXEC_XLEN];
      OP_DIV:   alu_result = div_zero ? '1 : quo_s;
      OP_DIVU:  alu_result = div_zero ? '1 : op1 / den_u;
      OP_REM:   alu_result = div_zero ? op1 : rem_s;
      OP_REMU:  alu_result = div_zero ? op1 : op1 % den_u;
      default:  alu_result = '0;
    endcase
  end

  ////////////////////
  // memory access.
  ////////////////////

  assign ea       = op1 + op2;
  assign is_load  = req_q.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  assign is_store = req_q.op inside {OP_SB, OP_SH, OP_SW};

  // misaligned stores get no byte enables.
  always_comb begin
    case (req_q.op)
      OP_SB:   wr_mask = byte_mask_t'(4'b0001 << ea[1:0]);
      OP_SH:   wr_mask = (ea[1:0] == 2'd3) ? '0 : byte_mask_t'(4'b0011 << ea[1:0]);
      OP_SW:   wr_mask = (ea[1:0] == 2'd0) ? 4'b1111 : '0;
      default: wr_mask = '0;
    endcase
  end

  always_comb begin
    rsp_d.op          = req_q.op;
    rsp_d.alu_result  = alu_result;
    rsp_d.rmem_addr   = is_load ? ea : '0;
    rsp_d.wmem_addr   = is_store ? ea : '0;
    rsp_d.wmem_mask   = wr_mask;
    rsp_d.read_offset = is_load ? byte_off_t'(ea[1:0]) : '0;
  end

  credit_fifo #(
    .payload_t (exec_rsp_t),
    .depth_p   (`EXEC_LANE_DEPTH)
  ) u_rsp_buf (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (req_vld_q),
    .push_data_i (rsp_d),
    .pop_i       (pop_i),
    .empty_o     (rsp_empty),
    .head_o      (rsp_o)
  );

  assign rsp_avail_o   = !rsp_empty;
  assign lane_credit_o = lane_credit_q;

endmodule

// File: verilog/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

////////////////////
// datapath sizing.
////////////////////

// data and address width.
`define EXEC_XLEN 32

////////////////////
// cluster shape and credit pools.
////////////////////

// execute lanes behind the dispatcher.
`define EXEC_LANES 4

// response entries per lane, also that lane's starting credit.
`define EXEC_LANE_DEPTH 2

// dispatcher input buffer entries, handed upstream as credits.
`define EXEC_IN_CREDITS 4

// credits the collector holds toward downstream at reset.
`define EXEC_OUT_CREDITS 2

`endif
